// File: common/i2c_pkg.sv
// Shared types and constants for the clocked I2C master; imported by each RTL block
`default_nettype none

package i2c_pkg;

   // 7-bit target device address
   typedef logic [6:0] dev_addr_t;

   // Register address or data byte
   typedef logic [7:0] byte_t;

   // Bit position inside a byte
   typedef logic [2:0] bit_idx_t;

   // Which byte of the transfer is being sent
   typedef logic [1:0] byte_num_t;

   // Bus symbols handed from the sequencer to the bit engine
   typedef enum logic [2:0]
   {
      sym_start,
      sym_stop,
      sym_tx_bit,
      sym_rx_bit,
      sym_ack_check
   } sym_kind_t;

   // R/W bit appended to the device address
   localparam logic RW_WRITE = 1'b0;
   localparam logic RW_READ  = 1'b1;

   // Defaults for the top-level parameters
   localparam int quarter_cycles_default = 4;
   localparam int fifo_depth_default     = 8;

endpackage

`default_nettype wire

// File: common/sym_stream_if.sv
// Bus-symbol stream between master blocks, used on both sides of the symbol FIFO
`timescale 1ns/10ps
`default_nettype none

interface sym_stream_if;
   import i2c_pkg::*;

   logic      push;
   sym_kind_t kind;
   logic      bit_val;
   logic      full;

   // Producer into the FIFO
   modport source (output push, output kind, output bit_val, input full);

   // FIFO write port
   modport sink (input push, input kind, input bit_val, output full);

   // FIFO read port, where full reads as empty and push as pop
   modport fwft_src (input push, output kind, output bit_val, output full);

   // Consumer of the FIFO head entry
   modport fwft_snk (output push, input kind, input bit_val, input full);

endinterface

`default_nettype wire

// File: design/sym_fifo.sv
// First-word-fall-through FIFO of pending bus symbols between sequencer and bit engine
`timescale 1ns/10ps
`default_nettype none

module sym_fifo
#(
   parameter int fifo_depth = i2c_pkg::fifo_depth_default
)
(
   input  wire             sda,
   input  wire             reset,
   sym_stream_if.sink      wr,
   sym_stream_if.fwft_src  rd
);
   import i2c_pkg::*;

   localparam int ptr_w = (fifo_depth > 1) ? $clog2(fifo_depth) : 1;
   localparam int cnt_w = $clog2(fifo_depth + 1);

   sym_kind_t         kind_mem [fifo_depth];
   logic              bit_mem  [fifo_depth];
   logic [ptr_w-1:0]  wr_ptr;
   logic [ptr_w-1:0]  rd_ptr;
   logic [cnt_w-1:0]  count;
   logic              pop;

   // Pointers wrap at the depth, which need not be a power of two
   function automatic logic [ptr_w-1:0] next_ptr(logic [ptr_w-1:0] p);
      return (p == ptr_w'(fifo_depth - 1)) ? '0 : p + 1'b1;
   endfunction

   assign wr.full    = (count == cnt_w'(fifo_depth));
   assign rd.full    = (count == '0);
   assign rd.kind    = kind_mem[rd_ptr];
   assign rd.bit_val = bit_mem[rd_ptr];
   assign pop        = rd.push && !rd.full;

   always_ff @(posedge sda)
   begin
      if (wr.push)
      begin
         kind_mem[wr_ptr] <= wr.kind;
         bit_mem[wr_ptr]  <= wr.bit_val;
      end
   end

   always_ff @(posedge sda)
   begin
      if (reset)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         if (wr.push)
            wr_ptr <= next_ptr(wr_ptr);
         if (pop)
            rd_ptr <= next_ptr(rd_ptr);
         if (wr.push && !pop)
            count <= count + 1'b1;
         else if (pop && !wr.push)
            count <= count - 1'b1;
      end
   end

endmodule

`default_nettype wire

// File: sequencer/i2c_cmd_sequencer.sv
// Expands one register write or read command into the I2C bus-symbol sequence
`timescale 1ns/10ps
`default_nettype none

module i2c_cmd_sequencer
(
   input  wire                      sda,
   input  wire                      reset,
   input  wire                      cmd_start,
   input  wire                      cmd_read,
   input  wire i2c_pkg::dev_addr_t  dev_addr,
   input  wire i2c_pkg::byte_t      reg_addr,
   input  wire i2c_pkg::byte_t      wr_data,
   input  wire                      done,
   output logic                     busy,
   sym_stream_if.source             sym
);
   import i2c_pkg::*;

   typedef enum logic [2:0]
   {
      st_idle,
      st_start,
      st_tx,
      st_ack,
      st_rx,
      st_nack,
      st_stop,
      st_wait
   } seq_state_t;

   seq_state_t state;
   logic       rd_cmd;
   logic       rd_phase;
   dev_addr_t  dev_q;
   byte_t      reg_q;
   byte_t      wr_q;
   byte_t      tx_byte;
   bit_idx_t   bit_cnt;
   byte_num_t  byte_num;
   logic       emit;
   logic       accept;

   // Busy drops together with the engine's done pulse
   assign busy   = (state != st_idle) && !((state == st_wait) && done);
   assign accept = cmd_start && !busy;

   always_comb
   begin
      sym.kind    = sym_tx_bit;
      sym.bit_val = 1'b0;
      emit        = 1'b1;
      case (state)
         st_start: sym.kind = sym_start;
         st_tx:    sym.bit_val = tx_byte[7];
         st_ack:   sym.kind = sym_ack_check;
         st_rx:    sym.kind = sym_rx_bit;
         // Master NACK after the last read bit
         st_nack:  sym.bit_val = 1'b1;
         st_stop:  sym.kind = sym_stop;
         default:  emit = 1'b0;
      endcase
   end

   assign sym.push = emit && !sym.full;

   always_ff @(posedge sda)
   begin
      if (reset)
      begin
         state    <= st_idle;
         rd_phase <= 1'b0;
         byte_num <= '0;
         bit_cnt  <= '0;
      end
      else if (accept)
      begin
         state    <= st_start;
         rd_phase <= 1'b0;
         byte_num <= '0;
      end
      else if (sym.push)
      begin
         case (state)
            st_start:
               bit_cnt <= 3'd7;
            st_tx:
            begin
               bit_cnt <= bit_cnt - 1'b1;
               if (bit_cnt == '0)
                  state <= st_ack;
            end
            st_ack:
            begin
               byte_num <= byte_num + 1'b1;
               bit_cnt  <= 3'd7;
               if (byte_num == 2'd1 && rd_cmd)
                  rd_phase <= 1'b1;
            end
            st_rx:
            begin
               bit_cnt <= bit_cnt - 1'b1;
               if (bit_cnt == '0)
                  state <= st_nack;
            end
            default: ;
         endcase
         // Next symbol group after a start, an ack, a NACK or a stop
         if (state == st_start)
            state <= st_tx;
         else if (state == st_ack)
         begin
            if (rd_phase)
               state <= st_rx;
            else if (byte_num == 2'd0)
               state <= st_tx;
            else if (byte_num == 2'd1)
               state <= rd_cmd ? st_start : st_tx;
            else
               state <= st_stop;
         end
         else if (state == st_nack)
            state <= st_stop;
         else if (state == st_stop)
            state <= st_wait;
      end
      else if (state == st_wait && done)
         state <= st_idle;
   end

   // Command latch and outgoing byte shifter
   always_ff @(posedge sda)
   begin
      if (accept)
      begin
         rd_cmd <= cmd_read;
         dev_q  <= dev_addr;
         reg_q  <= reg_addr;
         wr_q   <= wr_data;
      end
      else if (sym.push)
      begin
         if (state == st_start)
            tx_byte <= {dev_q, rd_phase ? RW_READ : RW_WRITE};
         else if (state == st_tx)
            tx_byte <= tx_byte << 1;
         else if (state == st_ack)
            tx_byte <= (byte_num == 2'd0) ? reg_q : wr_q;
      end
   end

endmodule

`default_nettype wire

// File: bit_engine/i2c_bit_engine.sv
// Runs bus symbols with quarter-period timing, drives the I2C lines and collects read data
`timescale 1ns/10ps
`default_nettype none

module i2c_bit_engine
#(
   parameter int quarter_cycles = i2c_pkg::quarter_cycles_default
)
(
   input  wire             sda,
   input  wire             reset,
   sym_stream_if.fwft_snk  sym,
   input  wire             bus_clk_in,
   input  wire             bus_data_in,
   output logic            bus_clk_oe,
   output logic            bus_data_oe,
   output i2c_pkg::byte_t  rd_data,
   output logic            ack_error,
   output logic            done
);
   import i2c_pkg::*;

   localparam int qcnt_w = $clog2(quarter_cycles + 1);

   typedef enum logic [2:0]
   {
      ph_idle,
      ph_q0,
      ph_q1,
      ph_q2,
      ph_q3,
      ph_q4
   } phase_t;

   phase_t             phase;
   phase_t             nxt_phase;
   logic [qcnt_w-1:0]  q_cnt;
   sym_kind_t          cur_kind;
   logic               cur_bit;
   sym_kind_t          nxt_kind;
   logic               nxt_bit;
   logic               bus_active;
   logic               stretch;
   logic               q_end;
   logic               sym_end;
   logic               stop_end;
   logic               take;
   logic               fresh_start;
   logic               sample;

   // Pull-low levels {clk, data} for one quarter of a symbol
   function automatic logic [1:0] drive(phase_t p, sym_kind_t k, logic b);
      logic clk_low;
      logic data_low;
      clk_low = (p == ph_q0) || ((p == ph_q3) && (k != sym_stop));
      case (k)
         sym_tx_bit: data_low = !b;
         // Falls with the clock high
         sym_start:  data_low = (p == ph_q2) || (p == ph_q3);
         // Rises with the clock high
         sym_stop:   data_low = (p == ph_q0) || (p == ph_q1);
         default:    data_low = 1'b0;
      endcase
      return {clk_low, data_low};
   endfunction

   // Target holding the clock low delays the high quarters
   assign stretch     = (phase == ph_q1) && !bus_clk_in;
   assign q_end       = (phase != ph_idle) && !stretch &&
                        (q_cnt == qcnt_w'(quarter_cycles - 1));
   assign sym_end     = q_end &&
                        ((phase == ph_q4) || ((phase == ph_q3) && (cur_kind != sym_stop)));
   assign stop_end    = sym_end && (cur_kind == sym_stop);
   assign take        = !sym.full && ((phase == ph_idle) || sym_end);
   assign sym.push    = take;
   assign nxt_kind    = take ? sym.kind : cur_kind;
   assign nxt_bit     = take ? sym.bit_val : cur_bit;
   assign fresh_start = take && (sym.kind == sym_start) && (!bus_active || stop_end);
   assign sample      = q_end && (phase == ph_q2);

   always_comb
   begin
      nxt_phase = phase;
      if (take)
         nxt_phase = ph_q0;
      else if (sym_end)
         nxt_phase = ph_idle;
      else if (q_end)
      begin
         case (phase)
            ph_q0:   nxt_phase = ph_q1;
            ph_q1:   nxt_phase = ph_q2;
            ph_q2:   nxt_phase = ph_q3;
            ph_q3:   nxt_phase = ph_q4;
            default: nxt_phase = ph_idle;
         endcase
      end
   end

   always_ff @(posedge sda)
   begin
      if (reset)
      begin
         phase       <= ph_idle;
         q_cnt       <= '0;
         bus_clk_oe  <= 1'b0;
         bus_data_oe <= 1'b0;
         bus_active  <= 1'b0;
         ack_error   <= 1'b0;
         done        <= 1'b0;
      end
      else
      begin
         phase <= nxt_phase;
         done  <= stop_end;
         if ((phase == ph_idle) || q_end)
            q_cnt <= '0;
         else if (!stretch)
            q_cnt <= q_cnt + 1'b1;
         // Lines keep their last level while waiting on an empty FIFO
         if ((nxt_phase != phase) && (nxt_phase != ph_idle))
            {bus_clk_oe, bus_data_oe} <= drive(nxt_phase, nxt_kind, nxt_bit);
         if (stop_end)
            bus_active <= 1'b0;
         if (take && (sym.kind == sym_start))
            bus_active <= 1'b1;
         if (fresh_start)
            ack_error <= 1'b0;
         else if (sample && (cur_kind == sym_ack_check) && bus_data_in)
            ack_error <= 1'b1;
      end
   end

   // Current symbol and received byte
   always_ff @(posedge sda)
   begin
      if (take)
      begin
         cur_kind <= sym.kind;
         cur_bit  <= sym.bit_val;
      end
      if (fresh_start)
         rd_data <= '0;
      else if (sample && (cur_kind == sym_rx_bit))
         rd_data <= {rd_data[6:0], bus_data_in};
   end

endmodule

`default_nettype wire

// File: design/i2c_master.sv
// Clocked I2C master top level; connects command sequencer, symbol FIFO and bit engine
`timescale 1ns/10ps
`default_nettype none

module i2c_master
#(
   parameter int quarter_cycles = i2c_pkg::quarter_cycles_default,
   parameter int fifo_depth     = i2c_pkg::fifo_depth_default
)
(
   input  wire                      sda,
   input  wire                      reset,
   input  wire                      cmd_start,
   input  wire                      cmd_read,
   input  wire i2c_pkg::dev_addr_t  dev_addr,
   input  wire i2c_pkg::byte_t      reg_addr,
   input  wire i2c_pkg::byte_t      wr_data,
   output logic                     busy,
   output logic                     done,
   output i2c_pkg::byte_t           rd_data,
   output logic                     ack_error,
   output logic                     bus_clk_oe,
   output logic                     bus_data_oe,
   input  wire                      bus_clk_in,
   input  wire                      bus_data_in
);

   // Sequencer to FIFO, and FIFO head to engine
   sym_stream_if sym_in ();
   sym_stream_if sym_out ();

   i2c_cmd_sequencer u_sequencer
   (
      .sda       (sda),
      .reset     (reset),
      .cmd_start (cmd_start),
      .cmd_read  (cmd_read),
      .dev_addr  (dev_addr),
      .reg_addr  (reg_addr),
      .wr_data   (wr_data),
      .done      (done),
      .busy      (busy),
      .sym       (sym_in.source)
   );

   sym_fifo #(.fifo_depth(fifo_depth)) u_fifo
   (
      .sda   (sda),
      .reset (reset),
      .wr    (sym_in.sink),
      .rd    (sym_out.fwft_src)
   );

   i2c_bit_engine #(.quarter_cycles(quarter_cycles)) u_engine
   (
      .sda         (sda),
      .reset       (reset),
      .sym         (sym_out.fwft_snk),
      .bus_clk_in  (bus_clk_in),
      .bus_data_in (bus_data_in),
      .bus_clk_oe  (bus_clk_oe),
      .bus_data_oe (bus_data_oe),
      .rd_data     (rd_data),
      .ack_error   (ack_error),
      .done        (done)
   );

endmodule

`default_nettype wire

// File: test/i2c_target_model.sv
// Behavioral I2C register target for the testbench; acknowledges one device address only
`timescale 1ns/10ps
`default_nettype none

module i2c_target_model
#(
   parameter logic [6:0] own_addr = 7'h3A
)
(
   input  wire   bus_clk,
   input  wire   bus_data,
   output logic  clk_oe,
   output logic  data_oe,
   output int    xfer_count
);

   // 0 idle, 1 device address, 2 register address, 3 write data, 4 read data
   int          state;
   int          bit_no;
   logic        in_xfer;
   logic        master_ack;
   logic [7:0]  shift;
   logic [7:0]  ptr;
   logic [7:0]  regs [256];

   initial
   begin
      clk_oe     = 1'b0;
      data_oe    = 1'b0;
      xfer_count = 0;
      state      = 0;
      bit_no     = 0;
      in_xfer    = 1'b0;
      master_ack = 1'b0;
      ptr        = '0;
      for (int i = 0; i < 256; i++)
         regs[i] = 8'(i) ^ 8'hA5;
   end

   // Start or repeated start, the clock pulse of the start itself is skipped
   always @(negedge bus_data)
   begin
      if (bus_clk === 1'b1)
      begin
         state   = 1;
         bit_no  = -1;
         in_xfer = 1'b1;
         data_oe = 1'b0;
      end
   end

   always @(posedge bus_data)
   begin
      if (bus_clk === 1'b1 && in_xfer)
      begin
         xfer_count = xfer_count + 1;
         in_xfer    = 1'b0;
         state      = 0;
         data_oe    = 1'b0;
      end
   end

   always @(posedge bus_clk)
   begin
      if (state != 0 && bit_no >= 0 && bit_no < 8)
         shift = {shift[6:0], bus_data};
      else if (state == 4 && bit_no == 8)
         master_ack = !bus_data;
   end

   // Data only changes while the clock is low
   always @(negedge bus_clk)
   begin
      if (state != 0)
      begin
         bit_no  = bit_no + 1;
         data_oe = 1'b0;
         if (bit_no == 8)
         begin
            if (state == 1 && shift[7:1] != own_addr)
               state = 0;
            else if (state == 2)
               ptr = shift;
            else if (state == 3)
            begin
               regs[ptr] = shift;
               ptr       = ptr + 1'b1;
            end
            // Ack slot, left to the master while sending
            data_oe = (state != 0) && (state != 4);
         end
         else if (bit_no == 9)
         begin
            bit_no = 0;
            if (state == 1)
               state = shift[0] ? 4 : 2;
            else if (state == 2)
               state = 3;
            else if (state == 4)
            begin
               ptr   = ptr + 1'b1;
               state = master_ack ? 4 : 0;
            end
         end
         if (state == 4 && bit_no < 8)
            data_oe = !regs[ptr][7 - bit_no];
      end
   end

endmodule

`default_nettype wire

// File: test/tb_i2c_master.sv
// Testbench top for the I2C master; runs register writes and reads against a model target
`timescale 1ns/10ps
`default_nettype none

module tb_i2c_master;

   localparam int quarter_cycles = 4;
   localparam int n_trans        = 11;
   localparam int cycle_limit    = n_trans * 200 * 4 * quarter_cycles;

   logic         sda;
   logic         reset;
   logic         cmd_start;
   logic         cmd_read;
   logic [6:0]   dev_addr;
   logic [7:0]   reg_addr;
   logic [7:0]   wr_data;
   wire          busy;
   wire          done;
   wire  [7:0]   rd_data;
   wire          ack_error;
   wire          dut_clk_oe;
   wire          dut_data_oe;
   wire          tgt_clk_oe;
   wire          tgt_data_oe;
   wire          bus_clk;
   wire          bus_data;
   wire  [31:0]  tgt_xfers;

   int           checks = 0;
   int           errors = 0;
   int           cycles = 0;
   int           done_count = 0;
   int           issued = 0;
   int           exp_starts = 0;
   int           starts_seen = 0;
   int           stops_seen = 0;
   int           run_len = 0;
   logic         run_valid = 1'b0;
   logic         prev_clk = 1'b1;
   logic         prev_data = 1'b1;
   logic [15:0]  lfsr;
   logic [7:0]   ra;
   logic [7:0]   wd;

   // Open-drain lines with pull-up
   assign bus_clk  = 1'b1 & !dut_clk_oe & !tgt_clk_oe;
   assign bus_data = 1'b1 & !dut_data_oe & !tgt_data_oe;

   i2c_master #(.quarter_cycles(quarter_cycles), .fifo_depth(8)) u_dut
   (
      .sda         (sda),
      .reset       (reset),
      .cmd_start   (cmd_start),
      .cmd_read    (cmd_read),
      .dev_addr    (dev_addr),
      .reg_addr    (reg_addr),
      .wr_data     (wr_data),
      .busy        (busy),
      .done        (done),
      .rd_data     (rd_data),
      .ack_error   (ack_error),
      .bus_clk_oe  (dut_clk_oe),
      .bus_data_oe (dut_data_oe),
      .bus_clk_in  (bus_clk),
      .bus_data_in (bus_data)
   );

   i2c_target_model #(.own_addr(7'h3A)) u_target
   (
      .bus_clk    (bus_clk),
      .bus_data   (bus_data),
      .clk_oe     (tgt_clk_oe),
      .data_oe    (tgt_data_oe),
      .xfer_count (tgt_xfers)
   );

   initial sda = 1'b0;
   always #50 sda = !sda;

   function automatic logic [15:0] lfsr_step(input logic [15:0] s);
      return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
   endfunction

   // One LFSR step per bit
   task automatic draw_byte(output logic [7:0] v);
      v = '0;
      for (int i = 0; i < 8; i++)
      begin
         lfsr = lfsr_step(lfsr);
         v    = {v[6:0], lfsr[0]};
      end
   endtask

   task automatic expect_equal(input logic [31:0] got, input logic [31:0] exp,
                               input string what);
      checks++;
      assert (got === exp)
      else
      begin
         errors++;
         $display("[ERROR] %0t ns: %s, got %0h, expected %0h", $time, what, got, exp);
      end
   endtask

   // Issue one command and return at the sample where done is high
   task automatic run_cmd(input logic rd, input logic [6:0] dev, input logic [7:0] ra_in,
                          input logic [7:0] wd_in, input logic poke);
      @(negedge sda);
      cmd_start = 1'b1;
      cmd_read  = rd;
      dev_addr  = dev;
      reg_addr  = ra_in;
      wr_data   = wd_in;
      @(negedge sda);
      cmd_start = 1'b0;
      expect_equal(busy, 1'b1, "busy after cmd_start");
      issued++;
      exp_starts += rd ? 2 : 1;
      if (poke)
      begin
         repeat (20) @(negedge sda);
         cmd_start = 1'b1;
         cmd_read  = !rd;
         dev_addr  = 7'h3B;
         @(negedge sda);
         cmd_start = 1'b0;
         expect_equal(busy, 1'b1, "busy during ignored cmd_start");
      end
      while (done !== 1'b1)
         @(negedge sda);
   endtask

   initial
   begin
      reset     = 1'b1;
      cmd_start = 1'b0;
      cmd_read  = 1'b0;
      dev_addr  = '0;
      reg_addr  = '0;
      wr_data   = '0;
      lfsr      = 16'd41689;
      repeat (3) @(negedge sda);
      reset = 1'b0;
      repeat (6)
      begin
         @(negedge sda);
         expect_equal({busy, done, dut_clk_oe, dut_data_oe}, 0, "idle outputs after reset");
      end
      // Write then read back, with extra cmd_start pulses in two of the commands
      for (int i = 0; i < 4; i++)
      begin
         draw_byte(ra);
         draw_byte(wd);
         run_cmd(1'b0, 7'h3A, ra, wd, i == 1);
         expect_equal(ack_error, 1'b0, "ack_error after write");
         run_cmd(1'b1, 7'h3A, ra, 8'h00, i == 2);
         expect_equal(rd_data, wd, "read data");
         expect_equal(ack_error, 1'b0, "ack_error after read");
      end
      // Nobody answers at 7'h3B, register keeps its value
      draw_byte(ra);
      draw_byte(wd);
      run_cmd(1'b0, 7'h3A, ra, wd, 1'b0);
      expect_equal(ack_error, 1'b0, "ack_error after write");
      run_cmd(1'b0, 7'h3B, ra, ~wd, 1'b0);
      expect_equal(ack_error, 1'b1, "ack_error without target");
      run_cmd(1'b1, 7'h3A, ra, 8'h00, 1'b0);
      expect_equal(rd_data, wd, "register after write to absent target");
      expect_equal(ack_error, 1'b0, "ack_error after read");
      repeat (40) @(negedge sda);
      expect_equal(done_count, issued, "done pulses per command");
      expect_equal(tgt_xfers, issued, "transactions seen by target");
      expect_equal(starts_seen, exp_starts, "start conditions on bus");
      expect_equal(stops_seen, issued, "stop conditions on bus");
      $display("checks: %0d, errors: %0d", checks, errors);
      if (errors == 0)
         $display("all tests passed");
      else
         $display("tests failed");
      $finish;
   end

   always @(negedge sda)
   begin
      if (!reset && done)
      begin
         done_count++;
         expect_equal(busy, 1'b0, "busy at done");
      end
   end

   // Bus monitor, a data edge with the clock high is a start or a stop
   always @(negedge sda)
   begin
      if (!reset)
      begin
         if (bus_clk && prev_clk && (bus_data != prev_data))
         begin
            if (bus_data)
            begin
               stops_seen++;
               run_valid = 1'b0;
            end
            else
               starts_seen++;
         end
         if (bus_clk && !prev_clk)
         begin
            run_len   = 1;
            run_valid = 1'b1;
         end
         else if (bus_clk)
            run_len++;
         else if (prev_clk && run_valid)
            expect_equal(run_len, 2 * quarter_cycles, "clock high time");
      end
      prev_clk  = bus_clk;
      prev_data = bus_data;
   end

   always @(posedge sda)
   begin
      cycles++;
      if (cycles >= cycle_limit)
      begin
         $display("Timeout: the run did not finish within %0d clock cycles", cycle_limit);
         $display("checks: %0d, errors: %0d", checks, errors);
         $display("tests failed");
         $finish;
      end
   end

endmodule

`default_nettype wire

// File: i2c_master.f
common/i2c_pkg.sv
common/sym_stream_if.sv
design/sym_fifo.sv
sequencer/i2c_cmd_sequencer.sv
bit_engine/i2c_bit_engine.sv
design/i2c_master.sv
test/i2c_target_model.sv
test/tb_i2c_master.sv
